//--- common/prec_pkg.sv
//====================
// precision codes and the subword views of one 64-bit word
//====================
`default_nettype none

package prec_pkg;

  // word and lane width
  localparam int DATA_W = 64;

  localparam int BYTES_PER_WORD  = DATA_W / 8;
  localparam int HALVES_PER_WORD = DATA_W / 16;
  localparam int WORDS_PER_WORD  = DATA_W / 32;

  //====================
  // subword precision
  //====================
  typedef enum logic [1:0] {
    INT8  = 2'd0,
    INT16 = 2'd1,
    INT32 = 2'd2,
    INT64 = 2'd3
  } prec_t;

  //====================
  // one word, four views
  //====================
  // element 0 of each view sits at the low end of the word
  typedef union packed {
    logic [BYTES_PER_WORD-1:0][7:0]   bytes;
    logic [HALVES_PER_WORD-1:0][15:0] halves;
    logic [WORDS_PER_WORD-1:0][31:0]  words;
    logic [DATA_W-1:0]                whole;
  } lane_word_u;

endpackage

`default_nettype wire

//--- common/wb_pkg.sv
//====================
// Wishbone widths shared by every bus block
//====================
`default_nettype none

package wb_pkg;

  // word address, one address per 64-bit word
  localparam int ADR_W = 10;

  // bus data follows the datapath word
  localparam int WB_DAT_W = prec_pkg::DATA_W;

endpackage

`default_nettype wire

//--- engine/subword_unpack.sv
//====================
// spreads packed subwords into zero-extended 64-bit lanes
//====================
`default_nettype none

module subword_unpack #(
  parameter int LANES = 4
) (
  input  wire logic [LANES*prec_pkg::DATA_W-1:0] packed_in,
  input  wire prec_pkg::prec_t                   prec,
  output logic [LANES*prec_pkg::DATA_W-1:0]      lanes_out
);

  import prec_pkg::*;

  lane_word_u src_word [LANES];

  genvar w;
  genvar n;

  // source words, viewed through the union
  for (w = 0; w < LANES; w++) begin : g_src
    assign src_word[w].whole = packed_in[w*DATA_W +: DATA_W];
  end

  //====================
  // per-lane select
  //====================
  // lane n takes subword n of the little-endian stream
  for (n = 0; n < LANES; n++) begin : g_lane
    logic [DATA_W-1:0] lane;

    always_comb begin
      case (prec)
        INT8: begin
          lane = DATA_W'(src_word[n / BYTES_PER_WORD].bytes[n % BYTES_PER_WORD]);
        end
        INT16: begin
          lane = DATA_W'(src_word[n / HALVES_PER_WORD].halves[n % HALVES_PER_WORD]);
        end
        INT32: begin
          lane = DATA_W'(src_word[n / WORDS_PER_WORD].words[n % WORDS_PER_WORD]);
        end
        default: begin
          lane = src_word[n].whole;
        end
      endcase
    end

    assign lanes_out[n*DATA_W +: DATA_W] = lane;
  end

endmodule

`default_nettype wire

//--- engine/unpack_engine.sv
//====================
// unpack engine: reads packed words, writes unpacked lanes
// Wishbone classic master with a lane buffer
//====================
`default_nettype none

module unpack_engine #(
  parameter int LANES = 4
) (
  input  wire logic                          clk,
  input  wire logic                          rst,
  // job control
  input  wire logic                          start,
  input  wire prec_pkg::prec_t               prec,
  input  wire logic [wb_pkg::ADR_W-1:0]      src_adr,
  input  wire logic [wb_pkg::ADR_W-1:0]      dst_adr,
  output logic                               busy,
  output logic                               done,
  // Wishbone master
  output logic                               cyc,
  output logic                               stb,
  output logic                               we,
  output logic [wb_pkg::ADR_W-1:0]           adr,
  output logic [wb_pkg::WB_DAT_W-1:0]        dat_w,
  input  wire logic [wb_pkg::WB_DAT_W-1:0]   dat_r,
  input  wire logic                          ack
);

  import prec_pkg::*;
  import wb_pkg::*;

  localparam int CNT_W = (LANES > 1) ? $clog2(LANES) : 1;
  localparam logic [CNT_W-1:0] LAST_IDX = CNT_W'(LANES - 1);

  localparam logic [1:0] ST_IDLE  = 2'd0;
  localparam logic [1:0] ST_READ  = 2'd1;
  localparam logic [1:0] ST_WRITE = 2'd2;

  logic [1:0]              state;
  logic [CNT_W-1:0]        idx;
  prec_t                   prec_q;
  logic [ADR_W-1:0]        src_q;
  logic [ADR_W-1:0]        dst_q;
  logic [LANES*DATA_W-1:0] lane_buf;
  logic [LANES*DATA_W-1:0] lanes;

  //====================
  // control FSM
  //====================
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ST_IDLE;
      idx   <= '0;
      cyc   <= 1'b0;
      done  <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (start) begin
            state <= ST_READ;
            idx   <= '0;
            cyc   <= 1'b1;
          end
        end
        ST_READ: begin
          if (ack) begin
            if (idx == LAST_IDX) begin
              // release the bus for one cycle before writing
              state <= ST_WRITE;
              idx   <= '0;
              cyc   <= 1'b0;
            end else begin
              idx <= idx + 1'b1;
            end
          end
        end
        ST_WRITE: begin
          if (!cyc) begin
            cyc <= 1'b1;
          end else if (ack) begin
            if (idx == LAST_IDX) begin
              state <= ST_IDLE;
              idx   <= '0;
              cyc   <= 1'b0;
              done  <= 1'b1;
            end else begin
              idx <= idx + 1'b1;
            end
          end
        end
        default: begin
          state <= ST_IDLE;
          cyc   <= 1'b0;
        end
      endcase
    end
  end

  // job settings and read data
  always_ff @(posedge clk) begin
    if (state == ST_IDLE && start) begin
      prec_q <= prec;
      src_q  <= src_adr;
      dst_q  <= dst_adr;
    end
    if (state == ST_READ && ack) begin
      lane_buf[idx*DATA_W +: DATA_W] <= dat_r;
    end
  end

  //====================
  // bus outputs
  //====================
  assign busy  = (state != ST_IDLE);
  assign stb   = cyc;
  assign we    = cyc & (state == ST_WRITE);
  assign adr   = ((state == ST_WRITE) ? dst_q : src_q) + ADR_W'(idx);
  assign dat_w = lanes[idx*DATA_W +: DATA_W];

  subword_unpack #(
    .LANES(LANES)
  ) u_unpack (
    .packed_in(lane_buf),
    .prec     (prec_q),
    .lanes_out(lanes)
  );

endmodule

`default_nettype wire

//--- hdl/wb_arbiter.sv
//====================
// round-robin arbiter joining host and engine masters onto one slave
//====================
`default_nettype none

module wb_arbiter (
  input  wire logic                          clk,
  input  wire logic                          rst,
  // master 0 is the host
  input  wire logic                          m0_cyc,
  input  wire logic                          m0_stb,
  input  wire logic                          m0_we,
  input  wire logic [wb_pkg::ADR_W-1:0]      m0_adr,
  input  wire logic [wb_pkg::WB_DAT_W-1:0]   m0_dat_w,
  output logic [wb_pkg::WB_DAT_W-1:0]        m0_dat_r,
  output logic                               m0_ack,
  // master 1 is the engine
  input  wire logic                          m1_cyc,
  input  wire logic                          m1_stb,
  input  wire logic                          m1_we,
  input  wire logic [wb_pkg::ADR_W-1:0]      m1_adr,
  input  wire logic [wb_pkg::WB_DAT_W-1:0]   m1_dat_w,
  output logic [wb_pkg::WB_DAT_W-1:0]        m1_dat_r,
  output logic                               m1_ack,
  // slave
  output logic                               s_cyc,
  output logic                               s_stb,
  output logic                               s_we,
  output logic [wb_pkg::ADR_W-1:0]           s_adr,
  output logic [wb_pkg::WB_DAT_W-1:0]        s_dat_w,
  input  wire logic [wb_pkg::WB_DAT_W-1:0]   s_dat_r,
  input  wire logic                          s_ack
);

  // last master on the bus, 0 for the host
  logic owner_q;
  // the bus was in use last cycle
  logic held_q;
  logic owner_cyc;
  logic gnt;

  assign owner_cyc = owner_q ? m1_cyc : m0_cyc;

  always_comb begin
    if (held_q && owner_cyc) begin
      gnt = owner_q;
    end else if (m0_cyc && m1_cyc) begin
      // a free bus goes to the master not granted last
      gnt = ~owner_q;
    end else if (m1_cyc) begin
      gnt = 1'b1;
    end else begin
      // park on the host when idle
      gnt = 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      owner_q <= 1'b0;
      held_q  <= 1'b0;
    end else begin
      held_q <= s_cyc;
      if (s_cyc) begin
        owner_q <= gnt;
      end
    end
  end

  //====================
  // routing
  //====================
  assign s_cyc   = gnt ? m1_cyc   : m0_cyc;
  assign s_stb   = gnt ? m1_stb   : m0_stb;
  assign s_we    = gnt ? m1_we    : m0_we;
  assign s_adr   = gnt ? m1_adr   : m0_adr;
  assign s_dat_w = gnt ? m1_dat_w : m0_dat_w;

  assign m0_ack   = s_ack & ~gnt;
  assign m1_ack   = s_ack & gnt;
  assign m0_dat_r = gnt ? '0 : s_dat_r;
  assign m1_dat_r = gnt ? s_dat_r : '0;

endmodule

`default_nettype wire

//--- hdl/wb_sram.sv
//====================
// single-port word SRAM behind a Wishbone classic slave
//====================
`default_nettype none

module wb_sram #(
  parameter int DEPTH = 256
) (
  input  wire logic                          clk,
  input  wire logic                          rst,
  input  wire logic                          cyc,
  input  wire logic                          stb,
  input  wire logic                          we,
  input  wire logic [wb_pkg::ADR_W-1:0]      adr,
  input  wire logic [wb_pkg::WB_DAT_W-1:0]   dat_w,
  output logic [wb_pkg::WB_DAT_W-1:0]        dat_r,
  output logic                               ack
);

  import wb_pkg::*;

  localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  logic [WB_DAT_W-1:0] mem [DEPTH];
  logic [IDX_W-1:0]    word_idx;
  logic                req;

  assign word_idx = IDX_W'(adr % DEPTH);

  // no new request in the cycle that carries an ack
  assign req = cyc & stb & ~ack;

  always_ff @(posedge clk) begin
    if (rst) begin
      ack <= 1'b0;
    end else begin
      ack <= req;
    end
  end

  always_ff @(posedge clk) begin
    if (req) begin
      if (we) begin
        mem[word_idx] <= dat_w;
      end
      dat_r <= mem[word_idx];
    end
  end

endmodule

`default_nettype wire

//--- hdl/unpack_top.sv
//====================
// operand unpacker top: engine, arbiter and SRAM
// with a host Wishbone port
//====================
`default_nettype none

module unpack_top #(
  parameter int LANES = 4,
  parameter int DEPTH = 256
) (
  input  wire logic                          clk,
  input  wire logic                          rst,
  // host port
  input  wire logic                          host_cyc,
  input  wire logic                          host_stb,
  input  wire logic                          host_we,
  input  wire logic [wb_pkg::ADR_W-1:0]      host_adr,
  input  wire logic [wb_pkg::WB_DAT_W-1:0]   host_dat_w,
  output logic [wb_pkg::WB_DAT_W-1:0]        host_dat_r,
  output logic                               host_ack,
  // engine control
  input  wire logic                          start,
  input  wire prec_pkg::prec_t               prec,
  input  wire logic [wb_pkg::ADR_W-1:0]      src_adr,
  input  wire logic [wb_pkg::ADR_W-1:0]      dst_adr,
  output logic                               busy,
  output logic                               done
);

  import wb_pkg::*;

  // engine master
  logic                eng_cyc;
  logic                eng_stb;
  logic                eng_we;
  logic [ADR_W-1:0]    eng_adr;
  logic [WB_DAT_W-1:0] eng_dat_w;
  logic [WB_DAT_W-1:0] eng_dat_r;
  logic                eng_ack;

  // arbiter to SRAM
  logic                mem_cyc;
  logic                mem_stb;
  logic                mem_we;
  logic [ADR_W-1:0]    mem_adr;
  logic [WB_DAT_W-1:0] mem_dat_w;
  logic [WB_DAT_W-1:0] mem_dat_r;
  logic                mem_ack;

  unpack_engine #(
    .LANES(LANES)
  ) u_engine (
    .clk    (clk),
    .rst    (rst),
    .start  (start),
    .prec   (prec),
    .src_adr(src_adr),
    .dst_adr(dst_adr),
    .busy   (busy),
    .done   (done),
    .cyc    (eng_cyc),
    .stb    (eng_stb),
    .we     (eng_we),
    .adr    (eng_adr),
    .dat_w  (eng_dat_w),
    .dat_r  (eng_dat_r),
    .ack    (eng_ack)
  );

  wb_arbiter u_arbiter (
    .clk     (clk),
    .rst     (rst),
    .m0_cyc  (host_cyc),
    .m0_stb  (host_stb),
    .m0_we   (host_we),
    .m0_adr  (host_adr),
    .m0_dat_w(host_dat_w),
    .m0_dat_r(host_dat_r),
    .m0_ack  (host_ack),
    .m1_cyc  (eng_cyc),
    .m1_stb  (eng_stb),
    .m1_we   (eng_we),
    .m1_adr  (eng_adr),
    .m1_dat_w(eng_dat_w),
    .m1_dat_r(eng_dat_r),
    .m1_ack  (eng_ack),
    .s_cyc   (mem_cyc),
    .s_stb   (mem_stb),
    .s_we    (mem_we),
    .s_adr   (mem_adr),
    .s_dat_w (mem_dat_w),
    .s_dat_r (mem_dat_r),
    .s_ack   (mem_ack)
  );

  wb_sram #(
    .DEPTH(DEPTH)
  ) u_sram (
    .clk  (clk),
    .rst  (rst),
    .cyc  (mem_cyc),
    .stb  (mem_stb),
    .we   (mem_we),
    .adr  (mem_adr),
    .dat_w(mem_dat_w),
    .dat_r(mem_dat_r),
    .ack  (mem_ack)
  );

endmodule

`default_nettype wire

//--- test/tb_unpack_top.sv
//====================
// directed testbench for the operand unpacker
// host traffic, unpack jobs and arbitration
//====================
`default_nettype none

module tb_unpack_top;
  timeunit 1ns;
  timeprecision 1ps;

  import prec_pkg::*;
  import wb_pkg::*;

  localparam int LANES = 4;
  localparam int NUM_MEM = 16;
  localparam int NUM_HOST = 4;

  //====================
  // run length limit
  //====================
  localparam int ACCESS_CYC = 4;
  localparam int JOB_CYC = 4 * LANES + 4;
  localparam int T_MEM = 8 + 2 * NUM_MEM * ACCESS_CYC;
  localparam int T_JOB = 2 * LANES * ACCESS_CYC + JOB_CYC + 4;
  // host accesses may wait out a whole engine phase
  localparam int T_ARB = T_JOB + 2 * NUM_HOST * (ACCESS_CYC + JOB_CYC);
  localparam int CYCLE_LIMIT = 4 * (T_MEM + 4 * T_JOB + T_ARB);

  logic                clk;
  logic                rst;
  logic                host_cyc;
  logic                host_stb;
  logic                host_we;
  logic [ADR_W-1:0]    host_adr;
  logic [WB_DAT_W-1:0] host_dat_w;
  logic [WB_DAT_W-1:0] host_dat_r;
  logic                host_ack;
  logic                start;
  prec_t               prec;
  logic [ADR_W-1:0]    src_adr;
  logic [ADR_W-1:0]    dst_adr;
  logic                busy;
  logic                done;

  logic [31:0] lfsr_state = 32'h91888002;
  logic [63:0] src_words [LANES];
  int          n_checks = 0;
  int          n_errors = 0;
  int          done_count = 0;
  int          cycle_count = 0;

  unpack_top #(
    .LANES(LANES),
    .DEPTH(256)
  ) UUT (
    .clk       (clk),
    .rst       (rst),
    .host_cyc  (host_cyc),
    .host_stb  (host_stb),
    .host_we   (host_we),
    .host_adr  (host_adr),
    .host_dat_w(host_dat_w),
    .host_dat_r(host_dat_r),
    .host_ack  (host_ack),
    .start     (start),
    .prec      (prec),
    .src_adr   (src_adr),
    .dst_adr   (dst_adr),
    .busy      (busy),
    .done      (done)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // done pulses are counted mid-cycle
  always @(negedge clk) begin
    if (done) begin
      done_count <= done_count + 1;
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("timeout: the run did not end within %0d cycles", CYCLE_LIMIT);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  //====================
  // stimulus and model
  //====================
  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  function automatic logic [63:0] rand_word();
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < 64; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[62:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // lane n is the n-th subword of the source byte stream
  function automatic logic [63:0] model_lane(input prec_t p, input int n);
    lane_word_u w;
    logic [7:0] stream [LANES*8];
    logic [63:0] v;
    int nbytes;
    for (int i = 0; i < LANES; i++) begin
      w.whole = src_words[i];
      for (int b = 0; b < 8; b++) begin
        stream[i*8 + b] = w.bytes[b];
      end
    end
    nbytes = 1 << int'(p);
    v = '0;
    for (int b = nbytes - 1; b >= 0; b--) begin
      v = {v[55:0], stream[n*nbytes + b]};
    end
    return v;
  endfunction

  task automatic check(input logic [63:0] got, input logic [63:0] exp, input string msg);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("MISMATCH at %0t: %s, got %h, expected %h", $time, msg, got, exp);
    end
  endtask

  //====================
  // bus and job tasks
  //====================
  task automatic wait_ack();
    @(negedge clk);
    while (!host_ack) begin
      @(negedge clk);
    end
  endtask

  // raises the host request in the current cycle
  task automatic host_request(input logic [ADR_W-1:0] a, input logic w, input logic [63:0] d);
    host_cyc   <= 1'b1;
    host_stb   <= 1'b1;
    host_we    <= w;
    host_adr   <= a;
    host_dat_w <= d;
  endtask

  task automatic host_release();
    @(posedge clk);
    host_cyc <= 1'b0;
    host_stb <= 1'b0;
    host_we  <= 1'b0;
  endtask

  task automatic host_write(input logic [ADR_W-1:0] a, input logic [63:0] d);
    @(posedge clk);
    host_request(a, 1'b1, d);
    wait_ack();
    host_release();
  endtask

  task automatic host_read(input logic [ADR_W-1:0] a, output logic [63:0] d);
    @(posedge clk);
    host_request(a, 1'b0, '0);
    wait_ack();
    d = host_dat_r;
    host_release();
  endtask

  // inputs change after start and the engine keeps its captured copy
  task automatic start_job(input prec_t p, input prec_t p_late,
                           input logic [ADR_W-1:0] s, input logic [ADR_W-1:0] d);
    @(posedge clk);
    start   <= 1'b1;
    prec    <= p;
    src_adr <= s;
    dst_adr <= d;
    @(posedge clk);
    start   <= 1'b0;
    prec    <= p_late;
    src_adr <= '0;
    dst_adr <= '0;
  endtask

  task automatic wait_done(input int count_before);
    while (done_count == count_before) begin
      @(negedge clk);
    end
    check(64'(busy), 64'd0, "busy after done");
  endtask

  task automatic load_source(input logic [ADR_W-1:0] s);
    for (int i = 0; i < LANES; i++) begin
      src_words[i] = rand_word();
      host_write(s + ADR_W'(i), src_words[i]);
    end
  endtask

  task automatic compare_result(input prec_t p, input logic [ADR_W-1:0] d);
    logic [63:0] got;
    for (int i = 0; i < LANES; i++) begin
      host_read(d + ADR_W'(i), got);
      check(got, model_lane(p, i), $sformatf("lane %0d at %0d", i, d + ADR_W'(i)));
    end
  endtask

  //====================
  // tests
  //====================
  task automatic reset_and_memory();
    logic [63:0] exp [NUM_MEM];
    logic [63:0] got;
    int err0;
    err0 = n_errors;
    @(negedge clk);
    check(64'(busy), 64'd0, "busy after reset");
    check(64'(done), 64'd0, "done after reset");
    check(64'(host_ack), 64'd0, "host_ack after reset");
    for (int i = 0; i < NUM_MEM; i++) begin
      exp[i] = rand_word();
      host_write(ADR_W'(i), exp[i]);
    end
    for (int i = 0; i < NUM_MEM; i++) begin
      host_read(ADR_W'(i), got);
      check(got, exp[i], $sformatf("readback at %0d", i));
    end
    $display("test reset and memory finished, %0d errors", n_errors - err0);
  endtask

  task automatic unpack_job(input string name, input prec_t p, input prec_t p_late,
                            input logic [ADR_W-1:0] s, input logic [ADR_W-1:0] d);
    int err0;
    int cnt;
    err0 = n_errors;
    load_source(s);
    cnt = done_count;
    start_job(p, p_late, s, d);
    wait_done(cnt);
    compare_result(p, d);
    $display("test %s finished, %0d errors", name, n_errors - err0);
  endtask

  task automatic arbitration_during_job();
    logic [63:0] exp [NUM_HOST];
    logic [63:0] got;
    int err0;
    int cnt;
    int waited;
    err0 = n_errors;
    for (int k = 0; k < NUM_HOST; k++) begin
      exp[k] = rand_word();
    end
    load_source(10'd128);
    cnt = done_count;
    start_job(INT16, INT16, 10'd128, 10'd144);
    // host and engine raise cyc together and the host was granted last
    host_request(ADR_W'(200), 1'b1, exp[0]);
    waited = 0;
    @(negedge clk);
    while (!host_ack) begin
      waited++;
      @(negedge clk);
    end
    check(64'(busy), 64'd1, "busy during job");
    // two cycles per engine read, then the host request cycle
    check(64'(waited), 64'(2 * LANES + 1), "host wait behind the engine reads");
    host_release();
    // host region at 200 lies clear of both engine regions
    for (int k = 1; k < NUM_HOST; k++) begin
      host_write(ADR_W'(200 + k), exp[k]);
    end
    for (int k = 0; k < NUM_HOST; k++) begin
      host_read(ADR_W'(200 + k), got);
      check(got, exp[k], $sformatf("host readback at %0d", 200 + k));
    end
    wait_done(cnt);
    compare_result(INT16, 10'd144);
    $display("test arbitration finished, %0d errors", n_errors - err0);
  endtask

  initial begin
    rst        <= 1'b1;
    host_cyc   <= 1'b0;
    host_stb   <= 1'b0;
    host_we    <= 1'b0;
    host_adr   <= '0;
    host_dat_w <= '0;
    start      <= 1'b0;
    prec       <= INT8;
    src_adr    <= '0;
    dst_adr    <= '0;
    repeat (3) @(posedge clk);
    rst <= 1'b0;

    reset_and_memory();
    unpack_job("int64 copy", INT64, INT64, 10'd32, 10'd40);
    unpack_job("int8 unpack", INT8, INT8, 10'd48, 10'd56);
    unpack_job("int16 unpack", INT16, INT8, 10'd64, 10'd72);
    unpack_job("int32 unpack", INT32, INT64, 10'd80, 10'd88);
    arbitration_during_job();

    $display("%0d checks, %0d errors", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
common/prec_pkg.sv
common/wb_pkg.sv
engine/subword_unpack.sv
engine/unpack_engine.sv
hdl/wb_arbiter.sv
hdl/wb_sram.sv
hdl/unpack_top.sv
test/tb_unpack_top.sv

//--- Makefile
# Verilator build and run for the operand unpacker testbench

VERILATOR ?= verilator
TOP       ?= tb_unpack_top
FLAGS     ?= --binary --timing -Wno-fatal
OBJ_DIR   ?= obj_dir
FILELIST  ?= verilog.f
PASS_MSG  := STATUS: PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "variables: VERILATOR, TOP, FLAGS, OBJ_DIR, FILELIST"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
